//--- Makefile
sim:
	verilator --binary --timing -Wno-fatal --top-module tb_wb_boot -f all.f -Mdir obj_dir
	./obj_dir/Vtb_wb_boot | tee sim.log
	grep -q "All tests passed!" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

//--- all.f
+incdir+common
common/wb_boot_pkg.sv
logic/wb_fetch_unit.sv
logic/wb_addr_decoder.sv
boot_rom/boot_rom.sv
logic/wb_ram.sv
logic/wb_boot_top.sv
testbench/tb_wb_boot.sv

//--- boot_rom/boot_rom.sv
`timescale 1ns/100ps
`include "wb_boot_settings.svh"

module boot_rom (
   input  logic                 wb_clk,
   input  logic                 wb_rst,
   input  wb_boot_pkg::wb_m2s_t wb_i,
   output wb_boot_pkg::wb_s2m_t wb_o
);
   import wb_boot_pkg::*;

   typedef logic [`ROM_ADR_W-1:0] rom_adr_t;

   rom_adr_t             adr_q;
   logic [`WB_DAT_W-1:0] dat_q;
   logic                 ack_q;
   logic                 stb_r;
   logic                 new_access_r;
   logic                 burst_r;
   logic                 new_access;
   logic                 burst;

   function automatic logic [`WB_DAT_W-1:0] rom_word(rom_adr_t adr);
      logic [`WB_DAT_W-1:0] word;
      case (adr)
         0:       word = 32'h1800_0000;
         1:       word = 32'hA820_0000;
         2:       word = 32'hA8C0_0100;
         3:       word = 32'h0000_0000;
         4:       word = 32'h1500_0000;
         default: word = 32'h0000_0000;
      endcase
      return word;
   endfunction

   assign new_access = wb_i.stb & ~stb_r;  // Rising strobe
   assign burst      = wb_i.cyc & wb_i.stb & (wb_i.cti == CTI_INCR);

   always_ff @(posedge wb_clk or posedge wb_rst) begin
      if (wb_rst) begin
         stb_r        <= 1'b0;
         new_access_r <= 1'b0;
         burst_r      <= 1'b0;
      end else begin
         stb_r        <= wb_i.stb;
         new_access_r <= new_access;
         burst_r      <= burst;
      end
   end

   // Address sequencer
   always_ff @(posedge wb_clk or posedge wb_rst) begin
      if (wb_rst) begin
         adr_q <= '0;
      end else if (new_access) begin
         adr_q <= wb_i.adr[`ROM_ADR_W+1:2];
      end else if (burst) begin
         adr_q <= rom_adr_t'(next_word(word_adr_t'(adr_q), wb_i.bte));
      end
   end

   always_ff @(posedge wb_clk) begin
      dat_q <= rom_word(adr_q);
   end

   // Two cycles to the first beat, then one beat per cycle
   always_ff @(posedge wb_clk or posedge wb_rst) begin
      if (wb_rst) begin
         ack_q <= 1'b0;
      end else if (ack_q & ~burst) begin
         ack_q <= 1'b0;  // Single done or CTI_END beat
      end else begin
         ack_q <= wb_i.stb & ((~burst & ~new_access & new_access_r) | (burst & burst_r));
      end
   end

   assign wb_o.dat = dat_q;
   assign wb_o.ack = ack_q;

endmodule

//--- common/wb_boot_pkg.sv
`include "wb_boot_settings.svh"

package wb_boot_pkg;

   // Cycle type identifier, B3 encoding
   typedef enum logic [2:0] {
      CTI_CLASSIC = 3'b000,
      CTI_INCR    = 3'b010,
      CTI_END     = 3'b111
   } cti_e;

   typedef enum logic [1:0] {
      BTE_LINEAR,
      BTE_WRAP4,
      BTE_WRAP8,
      BTE_WRAP16
   } bte_e;

   typedef logic [$clog2(`BURST_MAX):0] beat_cnt_t;
   typedef logic [`WB_ADR_W-3:0]        word_adr_t;

   typedef struct packed {
      logic [`WB_ADR_W-1:0] adr;    // Byte address
      logic                 we;
      logic [`WB_DAT_W-1:0] dat;
      beat_cnt_t            beats;  // 1 to BURST_MAX
      bte_e                 bte;
   } fetch_req_t;

   typedef struct packed {
      logic [`WB_DAT_W-1:0] dat;
   } fetch_rsp_t;

   typedef struct packed {
      logic [`WB_ADR_W-1:0] adr;
      logic [`WB_DAT_W-1:0] dat;
      logic                 we;
      logic                 cyc;
      logic                 stb;
      cti_e                 cti;
      bte_e                 bte;
   } wb_m2s_t;

   typedef struct packed {
      logic [`WB_DAT_W-1:0] dat;
      logic                 ack;
   } wb_s2m_t;

   // Next word of a burst, upper bits held under wrap
   function automatic word_adr_t next_word(word_adr_t wadr, bte_e bte);
      word_adr_t nxt;
      nxt = wadr;
      case (bte)
         BTE_WRAP4:  nxt[1:0] = wadr[1:0] + 2'd1;
         BTE_WRAP8:  nxt[2:0] = wadr[2:0] + 3'd1;
         BTE_WRAP16: nxt[3:0] = wadr[3:0] + 4'd1;
         default:    nxt = wadr + 1'b1;
      endcase
      return nxt;
   endfunction

endpackage

//--- common/wb_boot_settings.svh
`ifndef WB_BOOT_SETTINGS_SVH
`define WB_BOOT_SETTINGS_SVH

// Bus widths
`define WB_ADR_W  32
`define WB_DAT_W  32

// Word address widths of the slaves
`define ROM_ADR_W 5
`define RAM_ADR_W 6

// Region bases, each spans its own depth in words
`define ROM_BASE  32'h0000_0000
`define RAM_BASE  32'h0000_1000

// Longest burst and response FIFO depth
`define BURST_MAX 16

`endif

//--- logic/wb_addr_decoder.sv
`timescale 1ns/100ps
`include "wb_boot_settings.svh"

module wb_addr_decoder (
   input  logic                 wb_clk,
   input  logic                 wb_rst,
   input  wb_boot_pkg::wb_m2s_t wbm_i,
   output wb_boot_pkg::wb_s2m_t wbm_o,
   output wb_boot_pkg::wb_m2s_t rom_o,
   input  wb_boot_pkg::wb_s2m_t rom_i,
   output wb_boot_pkg::wb_m2s_t ram_o,
   input  wb_boot_pkg::wb_s2m_t ram_i
);
   localparam int ROM_LSB = `ROM_ADR_W + 2;
   localparam int RAM_LSB = `RAM_ADR_W + 2;

   logic rom_hit;
   logic ram_hit;
   logic def_ack_q;

   assign rom_hit = (wbm_i.adr >> ROM_LSB) == (`ROM_BASE >> ROM_LSB);
   assign ram_hit = (wbm_i.adr >> RAM_LSB) == (`RAM_BASE >> RAM_LSB);

   always_comb begin
      rom_o     = wbm_i;
      rom_o.stb = wbm_i.stb & rom_hit;
      ram_o     = wbm_i;
      ram_o.stb = wbm_i.stb & ram_hit;
   end

   // Unmapped access answers with zero
   always_ff @(posedge wb_clk or posedge wb_rst) begin
      if (wb_rst) begin
         def_ack_q <= 1'b0;
      end else begin
         def_ack_q <= wbm_i.cyc & wbm_i.stb & ~rom_hit & ~ram_hit & ~def_ack_q;
      end
   end

   always_comb begin
      if (rom_hit) begin
         wbm_o = rom_i;
      end else if (ram_hit) begin
         wbm_o = ram_i;
      end else begin
         wbm_o.dat = '0;
         wbm_o.ack = def_ack_q;
      end
   end

endmodule

//--- logic/wb_boot_top.sv
`timescale 1ns/100ps

module wb_boot_top (
   input  logic                    wb_clk,
   input  logic                    wb_rst,
   input  logic                    req_valid_i,
   output logic                    req_ready_o,
   input  wb_boot_pkg::fetch_req_t req_i,
   output logic                    rsp_valid_o,
   input  logic                    rsp_ready_i,
   output wb_boot_pkg::fetch_rsp_t rsp_o
);
   import wb_boot_pkg::*;

   wb_m2s_t m2s;
   wb_s2m_t s2m;
   wb_m2s_t rom_m2s;
   wb_s2m_t rom_s2m;
   wb_m2s_t ram_m2s;
   wb_s2m_t ram_s2m;

   wb_fetch_unit i_fetch (
      .wb_clk      (wb_clk),
      .wb_rst      (wb_rst),
      .req_valid_i (req_valid_i),
      .req_ready_o (req_ready_o),
      .req_i       (req_i),
      .rsp_valid_o (rsp_valid_o),
      .rsp_ready_i (rsp_ready_i),
      .rsp_o       (rsp_o),
      .wbm_o       (m2s),
      .wbm_i       (s2m)
   );

   wb_addr_decoder i_dec (
      .wb_clk (wb_clk),
      .wb_rst (wb_rst),
      .wbm_i  (m2s),
      .wbm_o  (s2m),
      .rom_o  (rom_m2s),
      .rom_i  (rom_s2m),
      .ram_o  (ram_m2s),
      .ram_i  (ram_s2m)
   );

   boot_rom i_rom (
      .wb_clk (wb_clk),
      .wb_rst (wb_rst),
      .wb_i   (rom_m2s),
      .wb_o   (rom_s2m)
   );

   wb_ram i_ram (
      .wb_clk (wb_clk),
      .wb_rst (wb_rst),
      .wb_i   (ram_m2s),
      .wb_o   (ram_s2m)
   );

endmodule

//--- logic/wb_fetch_unit.sv
`timescale 1ns/100ps
`include "wb_boot_settings.svh"

module wb_fetch_unit (
   input  logic                    wb_clk,
   input  logic                    wb_rst,
   input  logic                    req_valid_i,
   output logic                    req_ready_o,
   input  wb_boot_pkg::fetch_req_t req_i,
   output logic                    rsp_valid_o,
   input  logic                    rsp_ready_i,
   output wb_boot_pkg::fetch_rsp_t rsp_o,
   output wb_boot_pkg::wb_m2s_t    wbm_o,
   input  wb_boot_pkg::wb_s2m_t    wbm_i
);
   import wb_boot_pkg::*;

   localparam int        PTR_W = $clog2(`BURST_MAX);
   localparam beat_cnt_t DEPTH = beat_cnt_t'(`BURST_MAX);

   typedef enum logic {IDLE, BUS} state_e;

   state_e               state_q;
   wb_m2s_t              bus_q;
   beat_cnt_t            left_q;   // Beats still to be acknowledged
   beat_cnt_t            req_beats;
   beat_cnt_t            count_q;
   logic [PTR_W-1:0]     wr_ptr_q;
   logic [PTR_W-1:0]     rd_ptr_q;
   logic [`WB_DAT_W-1:0] fifo_mem [`BURST_MAX];
   logic                 req_fire;
   logic                 beat_done;
   logic                 push;
   logic                 pop;

   assign req_beats   = req_i.we ? beat_cnt_t'(1) : req_i.beats;  // Writes are single
   assign req_ready_o = (state_q == IDLE) && ((DEPTH - count_q) >= req_beats);
   assign req_fire    = req_valid_i & req_ready_o;
   assign beat_done   = (state_q == BUS) & wbm_i.ack;
   assign push        = beat_done & ~bus_q.we;
   assign pop         = rsp_valid_o & rsp_ready_i;

   assign wbm_o       = bus_q;
   assign rsp_valid_o = (count_q != '0);
   assign rsp_o.dat   = fifo_mem[rd_ptr_q];

   always_ff @(posedge wb_clk or posedge wb_rst) begin
      if (wb_rst) begin
         state_q <= IDLE;
         bus_q   <= '0;
         left_q  <= '0;
      end else begin
         case (state_q)
            IDLE: begin
               if (req_fire) begin
                  bus_q.adr <= req_i.adr;
                  bus_q.dat <= req_i.dat;
                  bus_q.we  <= req_i.we;
                  bus_q.cyc <= 1'b1;
                  bus_q.stb <= 1'b1;
                  bus_q.cti <= (req_beats == 1) ? CTI_CLASSIC : CTI_INCR;
                  bus_q.bte <= req_i.bte;
                  left_q    <= req_beats;
                  state_q   <= BUS;
               end
            end
            BUS: begin
               if (beat_done) begin
                  if (left_q == 1) begin
                     bus_q.cyc <= 1'b0;
                     bus_q.stb <= 1'b0;
                     bus_q.cti <= CTI_CLASSIC;
                     state_q   <= IDLE;
                  end else begin
                     bus_q.adr <= {next_word(bus_q.adr[`WB_ADR_W-1:2], bus_q.bte), 2'b00};
                     bus_q.cti <= (left_q == 2) ? CTI_END : CTI_INCR;
                     left_q    <= left_q - 1'b1;
                  end
               end
            end
            default: state_q <= IDLE;
         endcase
      end
   end

   // Response FIFO
   always_ff @(posedge wb_clk) begin
      if (push) begin
         fifo_mem[wr_ptr_q] <= wbm_i.dat;
      end
   end

   always_ff @(posedge wb_clk or posedge wb_rst) begin
      if (wb_rst) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         if (push) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;
         end
         if (pop) begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
         end
         count_q <= count_q + beat_cnt_t'(push) - beat_cnt_t'(pop);
      end
   end

endmodule

//--- logic/wb_ram.sv
`timescale 1ns/100ps
`include "wb_boot_settings.svh"

module wb_ram (
   input  logic                 wb_clk,
   input  logic                 wb_rst,
   input  wb_boot_pkg::wb_m2s_t wb_i,
   output wb_boot_pkg::wb_s2m_t wb_o
);
   import wb_boot_pkg::*;

   typedef logic [`RAM_ADR_W-1:0] ram_adr_t;

   logic [`WB_DAT_W-1:0] mem [2**`RAM_ADR_W];
   logic [`WB_DAT_W-1:0] dat_q;
   ram_adr_t             cnt_q;
   ram_adr_t             cur_adr;
   logic                 ack_q;
   logic                 sel;
   logic                 last;

   assign sel  = wb_i.cyc & wb_i.stb;
   assign last = (wb_i.cti == CTI_CLASSIC) || (wb_i.cti == CTI_END);

   // Bus address on the first beat, own counter after that
   assign cur_adr = ack_q ? cnt_q : wb_i.adr[`RAM_ADR_W+1:2];

   always_ff @(posedge wb_clk or posedge wb_rst) begin
      if (wb_rst) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= sel & ~(ack_q & last);
      end
   end

   always_ff @(posedge wb_clk) begin
      if (sel & wb_i.we & ~ack_q) begin
         mem[cur_adr] <= wb_i.dat;
      end
   end

   always_ff @(posedge wb_clk) begin
      dat_q <= mem[cur_adr];
      cnt_q <= ram_adr_t'(next_word(word_adr_t'(cur_adr), wb_i.bte));
   end

   assign wb_o.dat = dat_q;
   assign wb_o.ack = ack_q;

endmodule

//--- testbench/tb_wb_boot.sv
`timescale 1ns/100ps
`include "wb_boot_settings.svh"

module tb_wb_boot;
   import wb_boot_pkg::*;

   localparam int NUM_TESTS    = 21;
   localparam int NUM_MIXED    = 24;
   localparam int ACCEPT_LIMIT = 100;
   localparam int DRAIN_LIMIT  = 400;
   localparam int ROM_WORDS    = 2 ** `ROM_ADR_W;
   localparam int RAM_WORDS    = 2 ** `RAM_ADR_W;

   typedef struct packed {
      logic [31:0] adr;
      logic        we;
      logic [31:0] dat;
      beat_cnt_t   beats;
      bte_e        bte;
      logic [31:0] first;  // Expected first word of a read
   } entry_t;

   typedef struct packed {
      logic [31:0] model;
      logic [31:0] first;
      logic        has_first;
   } exp_t;

   logic       wb_clk = 1'b0;
   logic       wb_rst;
   logic       req_valid;
   logic       req_ready;
   fetch_req_t req;
   logic       rsp_valid;
   logic       rsp_ready;
   fetch_rsp_t rsp;

   logic [31:0] rom_model [ROM_WORDS];
   logic [31:0] ram_model [RAM_WORDS];
   exp_t        exp_q [$];
   int          mixed_idx [NUM_MIXED];
   int          err_cnt  = 0;
   int          chk_cnt  = 0;
   int          test_cnt = 0;
   int          rsp_cnt  = 0;
   int          exp_cnt  = 0;

   entry_t tests [NUM_TESTS] = '{
      '{32'h0000_0000, 1'b0, 32'h0000_0000, 5'd1,  BTE_LINEAR, 32'h1800_0000},
      '{32'h0000_0004, 1'b0, 32'h0000_0000, 5'd1,  BTE_LINEAR, 32'hA820_0000},
      '{32'h0000_0008, 1'b0, 32'h0000_0000, 5'd1,  BTE_LINEAR, 32'hA8C0_0100},
      '{32'h0000_000C, 1'b0, 32'h0000_0000, 5'd1,  BTE_LINEAR, 32'h0000_0000},
      '{32'h0000_0010, 1'b0, 32'h0000_0000, 5'd1,  BTE_LINEAR, 32'h1500_0000},
      '{32'h0000_0014, 1'b0, 32'h0000_0000, 5'd1,  BTE_LINEAR, 32'h0000_0000},
      '{32'h0000_2000, 1'b0, 32'h0000_0000, 5'd1,  BTE_LINEAR, 32'h0000_0000},  // Unmapped
      '{32'h0000_0000, 1'b0, 32'h0000_0000, 5'd8,  BTE_LINEAR, 32'h1800_0000},
      '{32'h0000_0008, 1'b0, 32'h0000_0000, 5'd4,  BTE_WRAP4,  32'hA8C0_0100},
      '{32'h0000_000C, 1'b0, 32'h0000_0000, 5'd8,  BTE_WRAP8,  32'h0000_0000},
      '{32'h0000_0010, 1'b0, 32'h0000_0000, 5'd16, BTE_WRAP16, 32'h1500_0000},
      '{32'h0000_0004, 1'b0, 32'h0000_0000, 5'd4,  BTE_WRAP4,  32'hA820_0000},
      '{32'h0000_1008, 1'b1, 32'h1111_1111, 5'd1,  BTE_LINEAR, 32'h0000_0000},
      '{32'h0000_100C, 1'b1, 32'h2222_2222, 5'd1,  BTE_LINEAR, 32'h0000_0000},
      '{32'h0000_1010, 1'b1, 32'h3333_3333, 5'd1,  BTE_LINEAR, 32'h0000_0000},
      '{32'h0000_1000, 1'b1, 32'h4444_4444, 5'd1,  BTE_LINEAR, 32'h0000_0000},
      '{32'h0000_1008, 1'b0, 32'h0000_0000, 5'd1,  BTE_LINEAR, 32'h1111_1111},
      '{32'h0000_100C, 1'b0, 32'h0000_0000, 5'd4,  BTE_WRAP4,  32'h2222_2222},
      '{32'h0000_1010, 1'b0, 32'h0000_0000, 5'd8,  BTE_WRAP8,  32'h3333_3333},
      '{32'h0000_1008, 1'b0, 32'h0000_0000, 5'd16, BTE_WRAP16, 32'h1111_1111},
      '{32'h0000_1000, 1'b0, 32'h0000_0000, 5'd4,  BTE_LINEAR, 32'h4444_4444}
   };

   wb_boot_top i_dut (
      .wb_clk      (wb_clk),
      .wb_rst      (wb_rst),
      .req_valid_i (req_valid),
      .req_ready_o (req_ready),
      .req_i       (req),
      .rsp_valid_o (rsp_valid),
      .rsp_ready_i (rsp_ready),
      .rsp_o       (rsp)
   );

   always #4 wb_clk = ~wb_clk;

   always @(posedge wb_clk) begin
      #1;
      rsp_ready = (($urandom % 4) != 0);  // Stall about one cycle in four
   end

   // Byte address of beat k, the low bits turn over inside the wrap line
   function automatic logic [31:0] beat_adr(logic [31:0] adr, int k, bte_e bte);
      int          len;
      logic [31:0] wadr;
      case (bte)
         BTE_WRAP4:  len = 4;
         BTE_WRAP8:  len = 8;
         BTE_WRAP16: len = 16;
         default:    len = 0;
      endcase
      wadr = adr >> 2;
      if (len == 0) begin
         wadr = wadr + k;
      end else begin
         wadr = (wadr & ~(len - 1)) | ((wadr + k) % len);
      end
      return wadr << 2;
   endfunction

   function automatic logic [31:0] model_read(logic [31:0] adr);
      logic [31:0] word;
      word = '0;
      if (adr >= `ROM_BASE && adr < `ROM_BASE + 4 * ROM_WORDS) begin
         word = rom_model[int'((adr - `ROM_BASE) >> 2)];
      end else if (adr >= `RAM_BASE && adr < `RAM_BASE + 4 * RAM_WORDS) begin
         word = ram_model[int'((adr - `RAM_BASE) >> 2)];
      end
      return word;
   endfunction

   function automatic logic [31:0] fill_word(logic [31:0] adr);
      return {adr[15:0] ^ 16'hC3A5, adr[31:16] ^ adr[15:0]};
   endfunction

   task automatic check_val(input logic [31:0] got, input logic [31:0] exp, input string what);
      chk_cnt++;
      if (got !== exp) begin
         err_cnt++;
         $display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
      end
   endtask

   task automatic end_run();
      $display("%0d tests, %0d checks, %0d errors", test_cnt, chk_cnt, err_cnt);
      if (err_cnt == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   endtask

   task automatic report_test(input string name, input int err_before);
      test_cnt++;
      $display("test %0d %s: %s", test_cnt, name, (err_cnt == err_before) ? "ok" : "FAILED");
   endtask

   // Entered and left 1 ns after a rising edge
   task automatic send_req(input entry_t e, input logic use_first);
      int   wait_cnt;
      int   k;
      exp_t x;
      req       = '{e.adr, e.we, e.dat, e.beats, e.bte};
      req_valid = 1'b1;
      wait_cnt  = 0;
      @(negedge wb_clk);
      while (!req_ready) begin
         wait_cnt++;
         if (wait_cnt == ACCEPT_LIMIT) begin
            err_cnt++;
            $display("Timeout: request to %h was never accepted", e.adr);
            end_run();
         end
         @(negedge wb_clk);
      end
      if (e.we) begin
         ram_model[int'((e.adr - `RAM_BASE) >> 2)] = e.dat;
      end else begin
         for (k = 0; k < int'(e.beats); k++) begin
            x.model     = model_read(beat_adr(e.adr, k, e.bte));
            x.first     = e.first;
            x.has_first = use_first && (k == 0);
            exp_q.push_back(x);
            exp_cnt++;
         end
      end
      @(posedge wb_clk);
      #1;
      req_valid = 1'b0;
   endtask

   task automatic wait_drained();
      int wait_cnt;
      wait_cnt = 0;
      while (exp_q.size() != 0) begin
         wait_cnt++;
         if (wait_cnt == DRAIN_LIMIT) begin
            err_cnt++;
            $display("Timeout: %0d read responses never arrived", exp_q.size());
            end_run();
         end
         @(posedge wb_clk);
         #1;
      end
   endtask

   // A word moves on the next edge when valid and ready are both high
   always @(negedge wb_clk) begin : collect
      exp_t x;
      if (rsp_valid && rsp_ready) begin
         rsp_cnt++;
         if (exp_q.size() == 0) begin
            err_cnt++;
            $display("Response %h at %0t arrived with no read outstanding", rsp.dat, $time);
         end else begin
            x = exp_q.pop_front();
            check_val(rsp.dat, x.model, "response word");
            if (x.has_first) begin
               check_val(rsp.dat, x.first, "first word");
            end
         end
      end
   end

   initial begin
      int     i;
      int     err_before;
      entry_t fill;
      void'($urandom(32'hded36ea1));
      for (i = 0; i < NUM_MIXED; i++) begin
         mixed_idx[i] = int'($urandom % NUM_TESTS);
      end
      wb_rst    = 1'b1;
      req_valid = 1'b0;
      req       = '0;
      rsp_ready = 1'b0;
      for (i = 0; i < ROM_WORDS; i++) begin
         rom_model[i] = '0;
      end
      rom_model[0] = 32'h1800_0000;  // Boot vector
      rom_model[1] = 32'hA820_0000;
      rom_model[2] = 32'hA8C0_0100;
      rom_model[4] = 32'h1500_0000;

      repeat (2) @(posedge wb_clk);
      #1;
      wb_rst = 1'b0;
      @(negedge wb_clk);
      check_val(rsp_valid, 1'b0, "rsp_valid after reset");
      check_val(req_ready, 1'b1, "req_ready after reset");
      report_test("reset state", 0);
      @(posedge wb_clk);
      #1;

      err_before = err_cnt;
      for (i = 0; i < RAM_WORDS; i++) begin
         fill = '{`RAM_BASE + 32'(4 * i), 1'b1, 32'h0, 5'd1, BTE_LINEAR, 32'h0};
         fill.dat = fill_word(fill.adr);
         send_req(fill, 1'b0);
      end
      report_test("RAM fill", err_before);

      for (i = 0; i < NUM_TESTS; i++) begin
         err_before = err_cnt;
         send_req(tests[i], 1'b1);
         wait_drained();
         report_test($sformatf("table %0d at %h", i, tests[i].adr), err_before);
      end

      // Back to back requests against a stalling response port
      err_before = err_cnt;
      for (i = 0; i < NUM_MIXED; i++) begin
         send_req(tests[mixed_idx[i]], 1'b0);
      end
      wait_drained();
      repeat (4) @(posedge wb_clk);
      check_val(rsp_cnt, exp_cnt, "response count");
      report_test("mixed stream", err_before);
      end_run();
   end

endmodule
